//--- project.f
common/capture_pkg.sv
camera/cam_framer.sv
camera/pixel_packer.sv
source/frame_stat.sv
source/capture_regs.sv
source/capture_top.sv
verif/capture_asserts.sv
verif/capture_checker.sv
verif/tb_capture.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the capture testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_capture -f project.f -o sim_capture; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_capture +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TESTS FAILED" sim.log; then
  exit 1
fi
exit 0

//--- verif/tb_capture.sv
`default_nettype none

module tb_capture;
  timeunit 1ns;
  timeprecision 1ps;
  import capture_pkg::*;

  localparam int NUM_TESTS   = 7;
  localparam int EOF_TIMEOUT = 200;

  logic                  clk_board;
  logic                  i_reset;
  logic                  i_cam_vsync;
  logic                  i_cam_href;
  logic [PIX_W-1:0]      i_cam_data;
  logic                  i_wr_en;
  logic [REG_ADDR_W-1:0] i_wr_addr;
  logic [REG_W-1:0]      i_wr_data;
  logic                  i_rd_en;
  logic [REG_ADDR_W-1:0] i_rd_addr;
  logic                  o_word_vld;
  logic [WORD_W-1:0]     o_word_data;
  logic [BE_W-1:0]       o_word_be;
  logic                  o_word_sof;
  logic                  o_word_eof;
  logic [REG_W-1:0]      o_rd_data;
  logic                  test_done;
  int                    test_id;
  int                    checks;
  int                    errors;
  int                    assert_fails;
  int                    tests_run;
  int                    t;
  logic [31:0]           lfsr;
  logic                  hung;

  // Columns: lines per frame, bytes per line, capture enable
  int frame_tab [NUM_TESTS][3] = '{
    '{2, 8, 1},
    '{3, 5, 1},
    '{1, 6, 1},
    '{2, 7, 0},
    '{4, 9, 1},
    '{1, 1, 1},
    '{2, 12, 1}
  };

  capture_top i_dut (.*);

  bind capture_top capture_asserts i_asserts (
    .clk_board  (clk_board),
    .i_reset    (i_reset),
    .o_word_vld (o_word_vld),
    .o_word_be  (o_word_be),
    .o_word_sof (o_word_sof),
    .o_word_eof (o_word_eof)
  );

  capture_checker i_checker (
    .clk_board   (clk_board),
    .i_reset     (i_reset),
    .i_cam_vsync (i_cam_vsync),
    .i_cam_href  (i_cam_href),
    .i_cam_data  (i_cam_data),
    .i_wr_en     (i_wr_en),
    .i_wr_addr   (i_wr_addr),
    .i_wr_data   (i_wr_data),
    .i_rd_en     (i_rd_en),
    .i_rd_addr   (i_rd_addr),
    .i_rd_data   (o_rd_data),
    .i_word_vld  (o_word_vld),
    .i_word_data (o_word_data),
    .i_word_be   (o_word_be),
    .i_word_sof  (o_word_sof),
    .i_word_eof  (o_word_eof),
    .i_test_done (test_done),
    .i_test_id   (test_id),
    .o_checks    (checks),
    .o_errors    (errors)
  );

  initial begin
    clk_board = 1'b0;
    forever #10 clk_board = ~clk_board;
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
  endfunction

  // One LFSR step per pixel bit
  task automatic take_byte(output logic [PIX_W-1:0] value);
    int i;
    for (i = 0; i < PIX_W; i++) begin
      value[i] = lfsr[0];
      lfsr     = lfsr_step(lfsr);
    end
  endtask

  task automatic write_reg(input logic [REG_ADDR_W-1:0] addr, input logic [REG_W-1:0] data);
    @(posedge clk_board);
    i_wr_en   <= 1'b1;
    i_wr_addr <= addr;
    i_wr_data <= data;
    @(posedge clk_board);
    i_wr_en <= 1'b0;
  endtask

  task automatic read_reg(input logic [REG_ADDR_W-1:0] addr);
    @(posedge clk_board);
    i_rd_en   <= 1'b1;
    i_rd_addr <= addr;
    @(posedge clk_board);
    i_rd_en <= 1'b0;
  endtask

  //====================================================================
  // Camera frame: vsync low, lines of href, gaps between lines
  //====================================================================
  task automatic drive_frame(input int lines, input int bytes);
    int               l;
    int               b;
    logic [PIX_W-1:0] pix;
    @(posedge clk_board);
    i_cam_vsync <= 1'b0;
    repeat (3) @(posedge clk_board);
    for (l = 0; l < lines; l++) begin
      for (b = 0; b < bytes; b++) begin
        take_byte(pix);
        @(posedge clk_board);
        i_cam_href <= 1'b1;
        i_cam_data <= pix;
      end
      @(posedge clk_board);
      i_cam_href <= 1'b0;
      repeat (3) @(posedge clk_board);
    end
    @(posedge clk_board);
    i_cam_vsync <= 1'b1;
  endtask

  task automatic wait_eof_word(input int test);
    int   cycles;
    logic seen;
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles < EOF_TIMEOUT) begin
      @(posedge clk_board);
      seen = o_word_vld && o_word_eof;
      cycles++;
    end
    if (!seen) begin
      $display("Timeout: test %0d never produced its end-of-frame word", test);
      hung = 1'b1;
    end
  endtask

  initial begin
    i_reset     = 1'b1;
    i_cam_vsync = 1'b1;
    i_cam_href  = 1'b0;
    i_cam_data  = '0;
    i_wr_en     = 1'b0;
    i_wr_addr   = '0;
    i_wr_data   = '0;
    i_rd_en     = 1'b0;
    i_rd_addr   = '0;
    test_done   = 1'b0;
    test_id     = 0;
    tests_run   = 0;
    hung        = 1'b0;
    lfsr        = 32'hd6e5;
    repeat (16) @(posedge clk_board);
    i_reset <= 1'b0;
    // Control register straight out of reset
    read_reg(ADDR_CTRL);
    for (t = 0; t < NUM_TESTS && !hung; t++) begin
      write_reg(ADDR_CTRL, {8'hc3, 4'(t), 3'b000, frame_tab[t][2] != 0});
      read_reg(ADDR_CTRL);
      repeat (4) @(posedge clk_board);
      drive_frame(frame_tab[t][0], frame_tab[t][1]);
      if (frame_tab[t][2] != 0) begin
        wait_eof_word(t);
      end else begin
        repeat (20) @(posedge clk_board);
      end
      if (!hung) begin
        read_reg(ADDR_LINES);
        read_reg(ADDR_LINE_BYTES);
        read_reg(ADDR_FRAMES);
        read_reg(ADDR_CHKSUM);
        read_reg(3'd7);
        @(posedge clk_board);
        test_done <= 1'b1;
        test_id   <= t;
        @(posedge clk_board);
        test_done <= 1'b0;
        tests_run++;
      end
    end
    repeat (4) @(posedge clk_board);
    assert_fails = i_dut.i_asserts.fail_cnt;
    $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
             tests_run, checks, errors, assert_fails);
    if (!hung && errors == 0 && assert_fails == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/capture_checker.sv
`default_nettype none

module capture_checker (
  input  logic                               clk_board,
  input  logic                               i_reset,
  input  logic                               i_cam_vsync,
  input  logic                               i_cam_href,
  input  logic [capture_pkg::PIX_W-1:0]      i_cam_data,
  input  logic                               i_wr_en,
  input  logic [capture_pkg::REG_ADDR_W-1:0] i_wr_addr,
  input  logic [capture_pkg::REG_W-1:0]      i_wr_data,
  input  logic                               i_rd_en,
  input  logic [capture_pkg::REG_ADDR_W-1:0] i_rd_addr,
  input  logic [capture_pkg::REG_W-1:0]      i_rd_data,
  input  logic                               i_word_vld,
  input  logic [capture_pkg::WORD_W-1:0]     i_word_data,
  input  logic [capture_pkg::BE_W-1:0]       i_word_be,
  input  logic                               i_word_sof,
  input  logic                               i_word_eof,
  input  logic                               i_test_done,
  input  int                                 i_test_id,
  output int                                 o_checks,
  output int                                 o_errors
);
  timeunit 1ns;
  timeprecision 1ps;
  import capture_pkg::*;

  // Captured bytes not yet seen in a word
  logic [PIX_W-1:0]  byte_q[$];
  logic [REG_W-1:0]  ctrl_m;
  logic              active_m;
  logic              vsync_q;
  logic              sof_next;
  logic              frame_has;
  logic [STAT_W-1:0] cur_line;
  logic [STAT_W-1:0] lines_m;
  logic [STAT_W-1:0] last_m;
  logic [CHK_W-1:0]  chk_m;
  logic [STAT_W-1:0] exp_lines;
  logic [STAT_W-1:0] exp_line_bytes;
  logic [STAT_W-1:0] exp_frames;
  logic [CHK_W-1:0]  exp_chk;
  logic              rd_pend;
  logic [REG_W-1:0]  rd_exp;
  int                test_errors;

  function automatic logic [REG_W-1:0] reg_value(input logic [REG_ADDR_W-1:0] addr);
    case (addr)
      ADDR_CTRL:       return ctrl_m;
      ADDR_LINES:      return exp_lines;
      ADDR_LINE_BYTES: return exp_line_bytes;
      ADDR_FRAMES:     return exp_frames;
      ADDR_CHKSUM:     return exp_chk;
      default:         return '0;
    endcase
  endfunction

  task automatic report_mismatch(input string msg);
    $display("Fail at %0t: %s", $time, msg);
    o_errors++;
    test_errors++;
  endtask

  task automatic check_value(input string what, input logic [WORD_W-1:0] got,
                             input logic [WORD_W-1:0] exp);
    o_checks++;
    if (got !== exp) begin
      report_mismatch($sformatf("%s is %h, expected %h", what, got, exp));
    end
  endtask

  //====================================================================
  // Word stream against the captured bytes
  //====================================================================
  task automatic check_word();
    int                n;
    int                i;
    logic [WORD_W-1:0] exp_word;
    n = i_word_eof ? byte_q.size() : BYTES_PER_WORD;
    exp_word = '0;
    if (n == 0 || n > BYTES_PER_WORD || byte_q.size() < n) begin
      o_checks++;
      report_mismatch($sformatf("word %h with eof %0b does not fit %0d pending bytes",
                                i_word_data, i_word_eof, byte_q.size()));
      byte_q.delete();
    end else begin
      // First byte sits in the low lane
      for (i = 0; i < n; i++) begin
        exp_word[PIX_W*i +: PIX_W] = byte_q.pop_front();
      end
      check_value("word data", i_word_data, exp_word);
      check_value("byte count field", WORD_W'(i_word_be), WORD_W'(n - 1));
      check_value("word sof", WORD_W'(i_word_sof), WORD_W'(sof_next));
    end
    sof_next = i_word_eof;
  endtask

  task automatic finish_test();
    o_checks++;
    if (byte_q.size() != 0) begin
      report_mismatch($sformatf("%0d captured bytes never left in a word", byte_q.size()));
    end
    o_checks++;
    if (!sof_next) begin
      report_mismatch("frame closed without an eof word");
    end
    if (test_errors == 0) begin
      $display("Test %0d ok", i_test_id);
    end else begin
      $display("Test %0d had %0d errors", i_test_id, test_errors);
    end
    test_errors = 0;
  endtask

  // Camera framing, line stats and control register as seen at the pins
  task automatic update_model();
    if (i_cam_href && !i_cam_vsync && active_m) begin
      byte_q.push_back(i_cam_data);
      chk_m     = chk_m + CHK_W'(i_cam_data);
      cur_line  = cur_line + 1'b1;
      frame_has = 1'b1;
    end else if (!i_cam_href && cur_line != '0) begin
      lines_m  = lines_m + 1'b1;
      last_m   = cur_line;
      cur_line = '0;
    end
    if (i_cam_vsync && !vsync_q && frame_has) begin
      exp_lines      = lines_m;
      exp_line_bytes = last_m;
      exp_chk        = chk_m;
      exp_frames     = exp_frames + 1'b1;
      lines_m        = '0;
      chk_m          = '0;
      frame_has      = 1'b0;
    end
    if (i_cam_vsync) begin
      active_m = ctrl_m[0];
    end
    if (i_wr_en && i_wr_addr == ADDR_CTRL) begin
      ctrl_m = i_wr_data;
    end
    vsync_q = i_cam_vsync;
  endtask

  always @(posedge clk_board) begin
    if (i_reset) begin
      byte_q.delete();
      ctrl_m         = '0;
      active_m       = 1'b0;
      vsync_q        = 1'b0;
      sof_next       = 1'b1;
      frame_has      = 1'b0;
      cur_line       = '0;
      lines_m        = '0;
      last_m         = '0;
      chk_m          = '0;
      exp_lines      = '0;
      exp_line_bytes = '0;
      exp_frames     = '0;
      exp_chk        = '0;
      rd_pend        = 1'b0;
      rd_exp         = '0;
      test_errors    = 0;
      o_checks       = 0;
      o_errors       = 0;
    end else begin
      // Read data belongs to the strobe one cycle back
      if (rd_pend) begin
        check_value("read data", WORD_W'(i_rd_data), WORD_W'(rd_exp));
      end
      rd_pend = i_rd_en;
      if (i_rd_en) begin
        rd_exp = reg_value(i_rd_addr);
      end
      if (i_word_vld) begin
        check_word();
      end
      if (i_test_done) begin
        finish_test();
      end
      update_model();
    end
  end

endmodule

`default_nettype wire

//--- verif/capture_asserts.sv
`default_nettype none

module capture_asserts (
  input logic                         clk_board,
  input logic                         i_reset,
  input logic                         o_word_vld,
  input logic [capture_pkg::BE_W-1:0] o_word_be,
  input logic                         o_word_sof,
  input logic                         o_word_eof
);
  timeunit 1ns;
  timeprecision 1ps;

  int fail_cnt = 0;

  // No word leaves the packer while reset is held
  reset_quiet: assert property (@(posedge clk_board) $past(i_reset) |-> !o_word_vld)
    else begin
      $error("word valid during reset");
      fail_cnt++;
    end

  // Only the last word of a frame may be partial
  full_unless_eof: assert property (@(posedge clk_board) disable iff (i_reset)
    !o_word_eof |-> (o_word_be == 2'd3))
    else begin
      $error("byte count field below 3 on a word without eof");
      fail_cnt++;
    end

  flags_need_vld: assert property (@(posedge clk_board) disable iff (i_reset)
    (o_word_sof || o_word_eof) |-> o_word_vld)
    else begin
      $error("frame flag raised without word valid");
      fail_cnt++;
    end

endmodule

`default_nettype wire

//--- source/capture_top.sv
`default_nettype none

module capture_top (
  input  logic                               clk_board,
  input  logic                               i_reset,
  input  logic                               i_cam_vsync,
  input  logic                               i_cam_href,
  input  logic [capture_pkg::PIX_W-1:0]      i_cam_data,
  input  logic                               i_wr_en,
  input  logic [capture_pkg::REG_ADDR_W-1:0] i_wr_addr,
  input  logic [capture_pkg::REG_W-1:0]      i_wr_data,
  input  logic                               i_rd_en,
  input  logic [capture_pkg::REG_ADDR_W-1:0] i_rd_addr,
  output logic                               o_word_vld,
  output logic [capture_pkg::WORD_W-1:0]     o_word_data,
  output logic [capture_pkg::BE_W-1:0]       o_word_be,
  output logic                               o_word_sof,
  output logic                               o_word_eof,
  output logic [capture_pkg::REG_W-1:0]      o_rd_data
);
  import capture_pkg::*;

  logic              en_cap;
  logic              pix_vld;
  logic [PIX_W-1:0]  pix_data;
  logic              pix_sof;
  logic              frame_end;
  logic [STAT_W-1:0] lines;
  logic [STAT_W-1:0] line_bytes;
  logic [STAT_W-1:0] frames;
  logic [CHK_W-1:0]  chksum;

  //====================================================================
  // Camera capture
  //====================================================================
  cam_framer i_cam_framer (
    .clk_board   (clk_board),
    .i_reset     (i_reset),
    .i_cam_vsync (i_cam_vsync),
    .i_cam_href  (i_cam_href),
    .i_cam_data  (i_cam_data),
    .i_en_cap    (en_cap),
    .o_pix_vld   (pix_vld),
    .o_pix_data  (pix_data),
    .o_pix_sof   (pix_sof),
    .o_frame_end (frame_end)
  );

  // Four bytes per word
  pixel_packer i_pixel_packer (
    .clk_board   (clk_board),
    .i_reset     (i_reset),
    .i_pix_vld   (pix_vld),
    .i_pix_data  (pix_data),
    .i_pix_sof   (pix_sof),
    .i_frame_end (frame_end),
    .o_word_vld  (o_word_vld),
    .o_word_data (o_word_data),
    .o_word_be   (o_word_be),
    .o_word_sof  (o_word_sof),
    .o_word_eof  (o_word_eof)
  );

  frame_stat i_frame_stat (
    .clk_board    (clk_board),
    .i_reset      (i_reset),
    .i_pix_vld    (pix_vld),
    .i_pix_data   (pix_data),
    .i_pix_sof    (pix_sof),
    .i_frame_end  (frame_end),
    .i_cam_href   (i_cam_href),
    .o_lines      (lines),
    .o_line_bytes (line_bytes),
    .o_frames     (frames),
    .o_chksum     (chksum)
  );

  //====================================================================
  // Register block
  //====================================================================
  capture_regs i_capture_regs (
    .clk_board    (clk_board),
    .i_reset      (i_reset),
    .i_wr_en      (i_wr_en),
    .i_wr_addr    (i_wr_addr),
    .i_wr_data    (i_wr_data),
    .i_rd_en      (i_rd_en),
    .i_rd_addr    (i_rd_addr),
    .i_lines      (lines),
    .i_line_bytes (line_bytes),
    .i_frames     (frames),
    .i_chksum     (chksum),
    .o_en_cap     (en_cap),
    .o_rd_data    (o_rd_data)
  );

endmodule

`default_nettype wire

//--- source/capture_regs.sv
`default_nettype none

module capture_regs (
  input  logic                               clk_board,
  input  logic                               i_reset,
  input  logic                               i_wr_en,
  input  logic [capture_pkg::REG_ADDR_W-1:0] i_wr_addr,
  input  logic [capture_pkg::REG_W-1:0]      i_wr_data,
  input  logic                               i_rd_en,
  input  logic [capture_pkg::REG_ADDR_W-1:0] i_rd_addr,
  input  logic [capture_pkg::STAT_W-1:0]     i_lines,
  input  logic [capture_pkg::STAT_W-1:0]     i_line_bytes,
  input  logic [capture_pkg::STAT_W-1:0]     i_frames,
  input  logic [capture_pkg::CHK_W-1:0]      i_chksum,
  output logic                               o_en_cap,
  output logic [capture_pkg::REG_W-1:0]      o_rd_data
);
  import capture_pkg::*;

  logic [REG_W-1:0] ctrl;

  assign o_en_cap = ctrl[CTRL_EN_BIT];

  always_ff @(posedge clk_board) begin
    if (i_reset) begin
      ctrl      <= CTRL_RST;
      o_rd_data <= '0;
    end else begin
      if (i_wr_en && (i_wr_addr == ADDR_CTRL)) begin
        ctrl <= i_wr_data;
      end

      // Read data one cycle after the strobe
      if (i_rd_en) begin
        case (i_rd_addr)
          ADDR_CTRL:       o_rd_data <= ctrl;
          ADDR_LINES:      o_rd_data <= REG_W'(i_lines);
          ADDR_LINE_BYTES: o_rd_data <= REG_W'(i_line_bytes);
          ADDR_FRAMES:     o_rd_data <= REG_W'(i_frames);
          ADDR_CHKSUM:     o_rd_data <= REG_W'(i_chksum);
          default:         o_rd_data <= '0;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

//--- source/frame_stat.sv
`default_nettype none

module frame_stat (
  input  logic                           clk_board,
  input  logic                           i_reset,
  input  logic                           i_pix_vld,
  input  logic [capture_pkg::PIX_W-1:0]  i_pix_data,
  input  logic                           i_pix_sof,
  input  logic                           i_frame_end,
  input  logic                           i_cam_href,
  output logic [capture_pkg::STAT_W-1:0] o_lines,
  output logic [capture_pkg::STAT_W-1:0] o_line_bytes,
  output logic [capture_pkg::STAT_W-1:0] o_frames,
  output logic [capture_pkg::CHK_W-1:0]  o_chksum
);
  import capture_pkg::*;

  logic              href_q;
  logic              href_fall;
  logic              line_seen;
  logic [STAT_W-1:0] byte_cnt;
  logic [STAT_W-1:0] line_cnt;
  logic [STAT_W-1:0] last_bytes;
  logic [CHK_W-1:0]  chk_acc;

  // Raw href falls together with the last framed byte of the line
  assign href_fall = href_q && !i_cam_href;
  assign line_seen = (byte_cnt != '0) || i_pix_vld;

  always_ff @(posedge clk_board) begin
    if (i_reset) begin
      href_q       <= 1'b0;
      byte_cnt     <= '0;
      line_cnt     <= '0;
      last_bytes   <= '0;
      chk_acc      <= '0;
      o_lines      <= '0;
      o_line_bytes <= '0;
      o_frames     <= '0;
      o_chksum     <= '0;
    end else begin
      href_q <= i_cam_href;

      // Running checksum, restarted by the first byte of a frame
      if (i_pix_vld && i_pix_sof) begin
        chk_acc  <= CHK_W'(i_pix_data);
        line_cnt <= '0;
      end else if (i_pix_vld) begin
        chk_acc <= chk_acc + CHK_W'(i_pix_data);
      end

      // Line length and line count, empty lines are skipped
      if (href_fall) begin
        byte_cnt <= '0;
        if (line_seen) begin
          last_bytes <= byte_cnt + STAT_W'(i_pix_vld);
          line_cnt   <= (i_pix_vld && i_pix_sof) ? STAT_W'(1) : line_cnt + 1'b1;
        end
      end else if (i_pix_vld) begin
        byte_cnt <= byte_cnt + 1'b1;
      end

      // Publish the frame results
      if (i_frame_end) begin
        o_lines      <= line_cnt;
        o_line_bytes <= last_bytes;
        o_chksum     <= chk_acc;
        o_frames     <= o_frames + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- camera/pixel_packer.sv
`default_nettype none

module pixel_packer (
  input  logic                           clk_board,
  input  logic                           i_reset,
  input  logic                           i_pix_vld,
  input  logic [capture_pkg::PIX_W-1:0]  i_pix_data,
  input  logic                           i_pix_sof,
  input  logic                           i_frame_end,
  output logic                           o_word_vld,
  output logic [capture_pkg::WORD_W-1:0] o_word_data,
  output logic [capture_pkg::BE_W-1:0]   o_word_be,
  output logic                           o_word_sof,
  output logic                           o_word_eof
);
  import capture_pkg::*;

  logic [WORD_W-1:0] acc;
  logic [WORD_W-1:0] acc_next;
  logic [BE_W-1:0]   cnt;
  logic              acc_sof;
  logic              word_sof;
  logic              word_full;
  logic              flush_part;
  // Full word waiting to learn whether it is the last one
  logic              pend_vld;
  logic [WORD_W-1:0] pend_data;
  logic              pend_sof;

  // New byte enters at the top, first byte ends up in the LSBs
  assign acc_next   = {i_pix_data, acc[WORD_W-1:PIX_W]};
  assign word_sof   = (cnt == '0) ? i_pix_sof : acc_sof;
  assign word_full  = i_pix_vld && (cnt == BE_W'(BYTES_PER_WORD - 1));
  assign flush_part = i_frame_end && !pend_vld && (cnt != '0);

  //====================================================================
  // Word control
  //====================================================================
  always_ff @(posedge clk_board) begin
    if (i_reset) begin
      cnt        <= '0;
      acc_sof    <= 1'b0;
      pend_vld   <= 1'b0;
      pend_sof   <= 1'b0;
      o_word_vld <= 1'b0;
      o_word_sof <= 1'b0;
      o_word_eof <= 1'b0;
    end else begin
      o_word_vld <= 1'b0;
      o_word_sof <= 1'b0;
      o_word_eof <= 1'b0;
      if (i_pix_vld) begin
        acc_sof <= word_sof;
        cnt     <= word_full ? '0 : cnt + 1'b1;
        // Another byte came, so the pending word was not the last
        if (pend_vld) begin
          o_word_vld <= 1'b1;
          o_word_sof <= pend_sof;
        end
        pend_vld <= word_full;
        if (word_full) begin
          pend_sof <= word_sof;
        end
      end else if (i_frame_end) begin
        if (pend_vld || flush_part) begin
          o_word_vld <= 1'b1;
          o_word_eof <= 1'b1;
          o_word_sof <= pend_vld ? pend_sof : acc_sof;
        end
        pend_vld <= 1'b0;
        cnt      <= '0;
      end
    end
  end

  //====================================================================
  // Word data
  //====================================================================
  always_ff @(posedge clk_board) begin
    o_word_be <= BE_W'(BYTES_PER_WORD - 1);
    if (i_pix_vld) begin
      acc         <= acc_next;
      o_word_data <= pend_data;
      if (word_full) begin
        pend_data <= acc_next;
      end
    end else if (i_frame_end) begin
      if (flush_part) begin
        // Move the leftover bytes down to the LSBs
        o_word_data <= acc >> (PIX_W * (BYTES_PER_WORD - int'(cnt)));
        o_word_be   <= cnt - 1'b1;
      end else begin
        o_word_data <= pend_data;
      end
    end
  end

endmodule

`default_nettype wire

//--- camera/cam_framer.sv
`default_nettype none

module cam_framer (
  input  logic                          clk_board,
  input  logic                          i_reset,
  input  logic                          i_cam_vsync,
  input  logic                          i_cam_href,
  input  logic [capture_pkg::PIX_W-1:0] i_cam_data,
  input  logic                          i_en_cap,
  output logic                          o_pix_vld,
  output logic [capture_pkg::PIX_W-1:0] o_pix_data,
  output logic                          o_pix_sof,
  output logic                          o_frame_end
);

  // Capture gate, only moves during blanking
  logic active;
  logic vsync_q;
  // Set once the current frame has delivered a byte
  logic has_pix;
  logic pix_take;
  logic vsync_rise;

  // A byte is taken only inside an active frame
  assign pix_take   = i_cam_href && !i_cam_vsync && active;
  assign vsync_rise = i_cam_vsync && !vsync_q;

  always_ff @(posedge clk_board) begin
    if (i_reset) begin
      active      <= 1'b0;
      vsync_q     <= 1'b0;
      has_pix     <= 1'b0;
      o_pix_vld   <= 1'b0;
      o_pix_sof   <= 1'b0;
      o_frame_end <= 1'b0;
    end else begin
      vsync_q   <= i_cam_vsync;
      o_pix_vld <= pix_take;
      o_pix_sof <= pix_take && !has_pix;

      // End of frame only for frames that carried data
      o_frame_end <= vsync_rise && has_pix;

      // Enable follows the register while vsync is high
      if (i_cam_vsync) begin
        active <= i_en_cap;
      end

      if (pix_take) begin
        has_pix <= 1'b1;
      end else if (vsync_rise) begin
        has_pix <= 1'b0;
      end
    end
  end

  // Byte lane, qualified by o_pix_vld
  always_ff @(posedge clk_board) begin
    o_pix_data <= i_cam_data;
  end

endmodule

`default_nettype wire

//--- common/capture_pkg.sv
`default_nettype none

package capture_pkg;

  //====================================================================
  // Data path widths
  //====================================================================

  // Camera byte
  localparam int PIX_W = 8;

  // Packed word and its byte count field
  localparam int WORD_W         = 32;
  localparam int BYTES_PER_WORD = 4;
  localparam int BE_W           = 2;

  //====================================================================
  // Register side
  //====================================================================

  localparam int REG_ADDR_W = 3;
  localparam int REG_W      = 16;

  // Statistics counters and checksum
  localparam int STAT_W = 16;
  localparam int CHK_W  = 16;

  // Register map
  localparam logic [REG_ADDR_W-1:0] ADDR_CTRL       = 3'd0;
  localparam logic [REG_ADDR_W-1:0] ADDR_LINES      = 3'd1;
  localparam logic [REG_ADDR_W-1:0] ADDR_LINE_BYTES = 3'd2;
  localparam logic [REG_ADDR_W-1:0] ADDR_FRAMES     = 3'd3;
  localparam logic [REG_ADDR_W-1:0] ADDR_CHKSUM     = 3'd4;

  // Control register fields
  localparam int CTRL_EN_BIT = 0;

  // Capture is off after reset
  localparam logic [REG_W-1:0] CTRL_RST = 16'h0000;

endpackage

`default_nettype wire
